//--- hw/ntm_sinh_defines.svh
// Widths, series length and Q4.12 coefficients for the sinh datapath
// Series length 1 to 4, each coefficient is 4096/((2k)(2k+1)) rounded
`ifndef NTM_SINH_DEFINES_SVH
`define NTM_SINH_DEFINES_SVH

// Element format, signed Q4.12
`define NTM_DATA_W 16
`define NTM_FRAC_W 12

// Row and column counts
`define NTM_SIZE_W 8

// Odd terms of the Taylor series, 1 to 4
`define NTM_SINH_TERMS 4

// term_k = term_(k-1) * x^2 * coef_k
`define NTM_COEF_1 683
`define NTM_COEF_2 205
`define NTM_COEF_3 98

`endif

//--- hw/ntm_sinh_pkg.sv
// Shared types of the matrix sinh datapath
// Widths come from the defines header

`include "ntm_sinh_defines.svh"

package ntm_sinh_pkg;

  // Signed Q4.12 element value
  typedef logic signed [`NTM_DATA_W-1:0] fix_t;

  // Full width product of two elements
  typedef logic signed [2*`NTM_DATA_W-1:0] prod_t;

  // Row or column count and index
  typedef logic [`NTM_SIZE_W-1:0] size_t;

  // Matrix controller
  typedef enum logic [1:0] {
    IDLE,
    WAIT_I,
    WAIT_J,
    COMPUTE
  } ctrl_state_t;

endpackage

//--- hw/ntm_sinh_elem_if.sv
// Element handshake between matrix controller and series unit
// One element in flight, start is not repeated before done

`timescale 1ns/1ps

interface ntm_sinh_elem_if;

  // Launch pulse and its operand
  logic               start;
  ntm_sinh_pkg::fix_t operand;

  // Completion pulse, result held until the next done
  logic               done;
  ntm_sinh_pkg::fix_t result;

  modport ctrl (
    output start,
    output operand,
    input  done,
    input  result
  );

  modport unit (
    input  start,
    input  operand,
    output done,
    output result
  );

endinterface

//--- hw/ntm_matrix_sinh_fsm.sv
// Row-major element sequencer, first element of a row waits on data_in_i_enable
// Input enables outside WAIT_I and WAIT_J are dropped

`timescale 1ns/1ps

module ntm_matrix_sinh_fsm (
  input  logic               CLK,
  input  logic               RST,

  // Matrix handshake
  input  logic               start,
  output logic               ready,
  input  logic               data_in_i_enable,
  input  logic               data_in_j_enable,
  output logic               data_out_i_enable,
  output logic               data_out_j_enable,

  // Element data
  input  ntm_sinh_pkg::fix_t data_in,
  output ntm_sinh_pkg::fix_t data_out,

  // Index counter
  output logic               cnt_clear,
  output logic               cnt_step,
  input  logic               row_end,
  input  logic               matrix_end,

  // Series unit
  ntm_sinh_elem_if.ctrl      elem
);

  ntm_sinh_pkg::ctrl_state_t state;
  logic                      take_elem;

  ////////////////////////////////////////
  // Counter control
  ////////////////////////////////////////

  // Sizes latched when start is accepted
  assign cnt_clear = (state == ntm_sinh_pkg::IDLE) && start;

  // Advance once per returned result
  assign cnt_step = (state == ntm_sinh_pkg::COMPUTE) && elem.done;

  // Element accepted from the environment
  assign take_elem = ((state == ntm_sinh_pkg::WAIT_I) && data_in_i_enable) ||
                     ((state == ntm_sinh_pkg::WAIT_J) && data_in_j_enable);

  ////////////////////////////////////////
  // State and output pulses
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= ntm_sinh_pkg::IDLE;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
      elem.start        <= 1'b0;
    end else begin
      // All pulses one cycle wide
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      elem.start        <= 1'b0;

      case (state)
        ntm_sinh_pkg::IDLE: begin
          if (start) begin
            state <= ntm_sinh_pkg::WAIT_I;
          end
        end
        ntm_sinh_pkg::WAIT_I, ntm_sinh_pkg::WAIT_J: begin
          // Launch on the cycle after the enable
          if (take_elem) begin
            elem.start <= 1'b1;
            state      <= ntm_sinh_pkg::COMPUTE;
          end
        end
        ntm_sinh_pkg::COMPUTE: begin
          if (elem.done) begin
            data_out          <= elem.result;
            data_out_j_enable <= 1'b1;
            // Flags still describe the element just finished
            if (matrix_end) begin
              ready <= 1'b1;
              state <= ntm_sinh_pkg::IDLE;
            end else if (row_end) begin
              data_out_i_enable <= 1'b1;
              state             <= ntm_sinh_pkg::WAIT_I;
            end else begin
              state <= ntm_sinh_pkg::WAIT_J;
            end
          end
        end
        default: begin
          state <= ntm_sinh_pkg::IDLE;
        end
      endcase
    end
  end

  // Operand captured with the accepted enable
  always_ff @(posedge CLK) begin
    if (take_elem) begin
      elem.operand <= data_in;
    end
  end

endmodule

//--- hw/ntm_matrix_index_counter.sv
// Row and column position with registered end flags, sizes of zero unsupported

`timescale 1ns/1ps

module ntm_matrix_index_counter (
  input  logic                CLK,
  input  logic                RST,
  input  logic                clear,
  input  logic                step,
  input  ntm_sinh_pkg::size_t size_i,
  input  ntm_sinh_pkg::size_t size_j,
  output logic                row_end,
  output logic                matrix_end
);

  // Latched sizes and current position
  ntm_sinh_pkg::size_t si_q, sj_q, row_q, col_q;
  ntm_sinh_pkg::size_t si_nxt, sj_nxt, row_nxt, col_nxt;
  logic                row_end_nxt;

  always_comb begin
    si_nxt  = si_q;
    sj_nxt  = sj_q;
    row_nxt = row_q;
    col_nxt = col_q;
    if (clear) begin
      si_nxt  = size_i;
      sj_nxt  = size_j;
      row_nxt = '0;
      col_nxt = '0;
    end else if (step) begin
      // Column wraps at each row end, row wraps at matrix end
      col_nxt = row_end ? '0 : col_q + ntm_sinh_pkg::size_t'(1);
      if (matrix_end) begin
        row_nxt = '0;
      end else if (row_end) begin
        row_nxt = row_q + ntm_sinh_pkg::size_t'(1);
      end
    end
  end

  // Flags describe the position being held
  assign row_end_nxt = (col_nxt == sj_nxt - ntm_sinh_pkg::size_t'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      si_q       <= '0;
      sj_q       <= '0;
      row_q      <= '0;
      col_q      <= '0;
      row_end    <= 1'b0;
      matrix_end <= 1'b0;
    end else begin
      si_q       <= si_nxt;
      sj_q       <= sj_nxt;
      row_q      <= row_nxt;
      col_q      <= col_nxt;
      row_end    <= row_end_nxt;
      matrix_end <= row_end_nxt && (row_nxt == si_nxt - ntm_sinh_pkg::size_t'(1));
    end
  end

endmodule

//--- hw/ntm_scalar_sinh_series.sv
// Truncated sinh series in Q4.12, x2, terms and sum all wrap at 16 bits
// done follows start by 2*NTM_SINH_TERMS cycles, one element at a time

`timescale 1ns/1ps
`include "ntm_sinh_defines.svh"

module ntm_scalar_sinh_series (
  input logic           CLK,
  input logic           RST,
  ntm_sinh_elem_if.unit elem
);

  // Step 0 forms x2, odd steps term*x2, even steps close a term
  localparam int LAST_STEP = 2 * `NTM_SINH_TERMS - 2;

  // Series state
  ntm_sinh_pkg::fix_t  x;
  ntm_sinh_pkg::fix_t  x2;
  ntm_sinh_pkg::fix_t  term;
  ntm_sinh_pkg::fix_t  partial;
  ntm_sinh_pkg::fix_t  sum;
  logic                busy;
  logic [2:0]          step_cnt;
  logic [1:0]          term_idx;
  logic                closes_term;
  logic                last_step;

  // Shared multiplier
  ntm_sinh_pkg::fix_t  mul_a;
  ntm_sinh_pkg::fix_t  mul_b;
  ntm_sinh_pkg::prod_t prod;
  ntm_sinh_pkg::fix_t  prod_q;
  ntm_sinh_pkg::fix_t  coef;
  ntm_sinh_pkg::fix_t  sum_nxt;

  assign term_idx    = step_cnt[2:1];
  assign closes_term = (step_cnt != 3'd0) && !step_cnt[0];
  assign last_step   = busy && (step_cnt == 3'(LAST_STEP));

  ////////////////////////////////////////
  // Multiplier and accumulate
  ////////////////////////////////////////

  // Coefficient of the term being closed
  always_comb begin
    case (term_idx)
      2'd1:    coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_1);
      2'd2:    coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_2);
      default: coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_3);
    endcase
  end

  always_comb begin
    if (step_cnt == 3'd0) begin
      mul_a = x;
      mul_b = x;
    end else if (step_cnt[0]) begin
      mul_a = term;
      mul_b = x2;
    end else begin
      mul_a = partial;
      mul_b = coef;
    end
  end

  // Signed full width product, arithmetic shift by the fraction bits
  assign prod    = mul_a * mul_b;
  assign prod_q  = prod[`NTM_FRAC_W+`NTM_DATA_W-1:`NTM_FRAC_W];
  assign sum_nxt = closes_term ? sum + prod_q : sum;

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      elem.done <= 1'b0;
    end else begin
      elem.done <= 1'b0;
      if (elem.start) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (last_step) begin
        busy      <= 1'b0;
        elem.done <= 1'b1;
      end else if (busy) begin
        step_cnt <= step_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (elem.start) begin
      // First term is x itself
      x    <= elem.operand;
      term <= elem.operand;
      sum  <= elem.operand;
    end else if (busy) begin
      if (step_cnt == 3'd0) begin
        x2 <= prod_q;
      end else if (step_cnt[0]) begin
        partial <= prod_q;
      end else begin
        term <= prod_q;
        sum  <= sum_nxt;
      end
    end
    // Result stays put until the next element finishes
    if (last_step) begin
      elem.result <= sum_nxt;
    end
  end

endmodule

//--- hw/ntm_matrix_sinh_function.sv
// Element-wise sinh over a row-major matrix in signed Q4.12
// Sizes sampled at start, first output 2*NTM_SINH_TERMS+2 cycles after its enable

`timescale 1ns/1ps

module ntm_matrix_sinh_function (
  input  logic                CLK,
  input  logic                RST,

  // Control
  input  logic                start,
  output logic                ready,
  input  logic                data_in_i_enable,
  input  logic                data_in_j_enable,
  output logic                data_out_i_enable,
  output logic                data_out_j_enable,

  // Data
  input  ntm_sinh_pkg::size_t size_i,
  input  ntm_sinh_pkg::size_t size_j,
  input  ntm_sinh_pkg::fix_t  data_in,
  output ntm_sinh_pkg::fix_t  data_out
);

  // Counter handshake
  logic cnt_clear;
  logic cnt_step;
  logic row_end;
  logic matrix_end;

  // Controller to series unit
  ntm_sinh_elem_if elem ();

  ntm_matrix_sinh_fsm matrix_sinh_fsm (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .data_in_i_enable  (data_in_i_enable),
    .data_in_j_enable  (data_in_j_enable),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .data_in           (data_in),
    .data_out          (data_out),
    .cnt_clear         (cnt_clear),
    .cnt_step          (cnt_step),
    .row_end           (row_end),
    .matrix_end        (matrix_end),
    .elem              (elem.ctrl)
  );

  ntm_matrix_index_counter index_counter (
    .CLK        (CLK),
    .RST        (RST),
    .clear      (cnt_clear),
    .step       (cnt_step),
    .size_i     (size_i),
    .size_j     (size_j),
    .row_end    (row_end),
    .matrix_end (matrix_end)
  );

  ntm_scalar_sinh_series scalar_sinh_series (
    .CLK  (CLK),
    .RST  (RST),
    .elem (elem.unit)
  );

endmodule

//--- bench/ntm_sinh_clock_gen.sv
// Free-running testbench clock and active-high reset held for a fixed number of cycles
// Reset drops 1 ns after a rising edge, clear of the 2 ns input drive point

`timescale 1ns/1ps

module ntm_sinh_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

//--- bench/ntm_matrix_sinh_tb.sv
// Matrices from a stimulus table run back to back through the DUT
// Expected values come from a Q4.12 series model that wraps at 16 bits on every step

`timescale 1ns/1ps
`include "ntm_sinh_defines.svh"

module ntm_matrix_sinh_tb;

  localparam int NUM_TESTS   = 8;
  localparam int TOTAL_ELEMS = 29;
  localparam int TIMEOUT     = 200;
  localparam int LATENCY     = 2 * `NTM_SINH_TERMS + 2;
  localparam int DRIVE_DELAY = 2;

  logic                CLK;
  logic                RST;
  logic                start;
  logic                ready;
  logic                data_in_i_enable;
  logic                data_in_j_enable;
  logic                data_out_i_enable;
  logic                data_out_j_enable;
  ntm_sinh_pkg::size_t size_i;
  ntm_sinh_pkg::size_t size_j;
  ntm_sinh_pkg::fix_t  data_in;
  ntm_sinh_pkg::fix_t  data_out;

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  // One row per matrix, gap is the largest random pause between enables
  string test_name [NUM_TESTS] = '{"one_zero", "one_half", "one_neg_half", "one_and_half",
                                   "rect_2x3", "rand_gaps_3x4", "col_3x1", "row_1x4"};
  int    test_rows [NUM_TESTS] = '{1, 1, 1, 1, 2, 3, 3, 1};
  int    test_cols [NUM_TESTS] = '{1, 1, 1, 1, 3, 4, 1, 4};
  int    test_gap  [NUM_TESTS] = '{0, 0, 0, 0, 0, 5, 0, 0};
  int    test_base [NUM_TESTS];

  // Elements of all matrices in row-major order, Q4.12 raw values
  int stim_vals [TOTAL_ELEMS] = '{
    0, 2048, -2048, 6144,
    1024, -1024, 4096, -4096, 7000, -6000,
    0, 300, -300, 1500, -2500, 3333, -3333, 5000, -5000, 7777, -7777, 8000,
    4096, 2048, -6144,
    -4096, 100, -100, 7900
  };
  ntm_sinh_pkg::fix_t stim_exp [TOTAL_ELEMS];

  // Bookkeeping
  int     errors;
  int     checks;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  int     wait_cnt;
  logic   timed_out;
  integer seed;

  ntm_sinh_clock_gen clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_matrix_sinh_function ntm_matrix_sinh_function_i (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .data_in_i_enable  (data_in_i_enable),
    .data_in_j_enable  (data_in_j_enable),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .size_i            (size_i),
    .size_j            (size_j),
    .data_in           (data_in),
    .data_out          (data_out)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Coefficient for series step k
  function automatic ntm_sinh_pkg::fix_t series_coef(input int k);
    case (k)
      1:       series_coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_1);
      2:       series_coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_2);
      default: series_coef = ntm_sinh_pkg::fix_t'(`NTM_COEF_3);
    endcase
  endfunction

  // Signed Q4.12 product, floor shift, kept to 16 bits
  function automatic ntm_sinh_pkg::fix_t q_mul(input ntm_sinh_pkg::fix_t a,
                                               input ntm_sinh_pkg::fix_t b);
    ntm_sinh_pkg::prod_t p;
    p     = a * b;
    q_mul = ntm_sinh_pkg::fix_t'(p >>> `NTM_FRAC_W);
  endfunction

  // x + x^3/3! + ... over the configured odd terms
  function automatic ntm_sinh_pkg::fix_t sinh_model(input ntm_sinh_pkg::fix_t x);
    ntm_sinh_pkg::fix_t x2;
    ntm_sinh_pkg::fix_t term;
    ntm_sinh_pkg::fix_t sum;
    x2   = q_mul(x, x);
    term = x;
    sum  = x;
    for (int k = 1; k < `NTM_SINH_TERMS; k++) begin
      term = q_mul(q_mul(term, x2), series_coef(k));
      sum  = sum + term;
    end
    sinh_model = sum;
  endfunction

  task automatic fill_expected();
    int base;
    base = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_base[t] = base;
      base         = base + test_rows[t] * test_cols[t];
    end
    if (base != TOTAL_ELEMS) begin
      $display("Stimulus table holds %0d elements but the matrices need %0d", TOTAL_ELEMS, base);
      errors++;
    end
    for (int n = 0; n < TOTAL_ELEMS; n++) begin
      stim_exp[n] = sinh_model(ntm_sinh_pkg::fix_t'(stim_vals[n]));
    end
  endtask

  ////////////////////////////////////////
  // Checks and cycle helpers
  ////////////////////////////////////////

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_fix(input string name, input string what,
                           input ntm_sinh_pkg::fix_t exp, input ntm_sinh_pkg::fix_t act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %0d actual %0d", name, what, exp, act);
      count_error();
    end
  endtask

  task automatic check_flag(input string name, input string what,
                            input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %b actual %b", name, what, exp, act);
      count_error();
    end
  endtask

  // Sample and drive point, 2 ns past the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  // Cycles with nothing in flight, no pulse allowed
  task automatic idle_cycles(input string name, input int n);
    repeat (n) begin
      next_cycle();
      if (ready || data_out_i_enable || data_out_j_enable) begin
        $display("%s: an output pulse appeared while no element was in flight", name);
        count_error();
      end
    end
  endtask

  // Waits for data_out_j_enable, enables dropped after one cycle
  task automatic wait_for_output(input string name, input bit first, output bit seen);
    int lat;
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < TIMEOUT) begin
      next_cycle();
      lat++;
      data_in_i_enable = 1'b0;
      data_in_j_enable = 1'b0;
      // Operand only valid together with its enable
      if (lat == 1) begin
        data_in = ~data_in;
      end
      // First element of a matrix has a fixed latency
      if (first && (lat == LATENCY || data_out_j_enable)) begin
        check_flag(name, "data_out_j_enable at first output latency",
                   lat == LATENCY, data_out_j_enable);
      end
      if (data_out_j_enable) begin
        seen = 1'b1;
      end else if (ready || data_out_i_enable) begin
        $display("%s: ready or data_out_i_enable pulsed without data_out_j_enable", name);
        count_error();
      end
    end
    if (!seen) begin
      $display("%s: timed out after %0d cycles waiting for data_out_j_enable", name, TIMEOUT);
      count_error();
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, test_errors);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // Enables while idle, outputs must stay at 0
  task automatic check_idle_quiet();
    string name;
    name             = "idle_quiet";
    test_errors      = 0;
    data_in          = ntm_sinh_pkg::fix_t'(4096);
    data_in_i_enable = 1'b1;
    next_cycle();
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b1;
    next_cycle();
    data_in_j_enable = 1'b0;
    repeat (LATENCY + 10) begin
      next_cycle();
      check_flag(name, "ready", 1'b0, ready);
      check_flag(name, "data_out_i_enable", 1'b0, data_out_i_enable);
      check_flag(name, "data_out_j_enable", 1'b0, data_out_j_enable);
      check_fix(name, "data_out", '0, data_out);
    end
    finish_test(name);
  endtask

  // One matrix, started in the cycle where the previous one finished
  task automatic run_matrix(input int t);
    string name;
    int    n;
    int    gap;
    int    idx;
    int    col;
    bit    seen;
    name        = test_name[t];
    n           = test_rows[t] * test_cols[t];
    test_errors = 0;
    start       = 1'b1;
    size_i      = ntm_sinh_pkg::size_t'(test_rows[t]);
    size_j      = ntm_sinh_pkg::size_t'(test_cols[t]);
    next_cycle();
    start = 1'b0;
    // Sizes count only at start, other values afterwards
    size_i = ntm_sinh_pkg::size_t'(test_rows[t] + 1);
    size_j = ntm_sinh_pkg::size_t'(test_cols[t] + 1);
    for (int e = 0; e < n && !timed_out; e++) begin
      gap = (test_gap[t] > 0) ? {$random(seed)} % (test_gap[t] + 1) : 0;
      idle_cycles(name, gap);
      idx     = test_base[t] + e;
      col     = e % test_cols[t];
      data_in = ntm_sinh_pkg::fix_t'(stim_vals[idx]);
      // Row start on the i enable, the rest on the j enable
      if (col == 0) begin
        data_in_i_enable = 1'b1;
      end else begin
        data_in_j_enable = 1'b1;
      end
      wait_for_output(name, e == 0, seen);
      if (seen) begin
        check_fix(name, $sformatf("data_out of element %0d", e), stim_exp[idx], data_out);
        check_flag(name, $sformatf("data_out_i_enable at element %0d", e),
                   (col == test_cols[t] - 1) && (e != n - 1), data_out_i_enable);
        check_flag(name, $sformatf("ready at element %0d", e), e == n - 1, ready);
      end
    end
    finish_test(name);
  endtask

  initial begin
    seed             = 59183;
    errors           = 0;
    checks           = 0;
    test_errors      = 0;
    tests_run        = 0;
    tests_failed     = 0;
    timed_out        = 1'b0;
    start            = 1'b0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    size_i           = '0;
    size_j           = '0;
    data_in          = '0;
    fill_expected();

    // Reset release
    wait_cnt = 0;
    while (RST !== 1'b0 && wait_cnt < TIMEOUT) begin
      next_cycle();
      wait_cnt++;
    end
    if (RST !== 1'b0) begin
      $display("Reset was still asserted after %0d cycles", TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end

    if (!timed_out) begin
      check_idle_quiet();
    end
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_matrix(t);
    end
    // No stray pulse after the last matrix
    if (!timed_out) begin
      test_errors = 0;
      idle_cycles("after_last", LATENCY + 4);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- ntm_matrix_sinh_function.f
+incdir+hw
hw/ntm_sinh_pkg.sv
hw/ntm_sinh_elem_if.sv
hw/ntm_matrix_sinh_fsm.sv
hw/ntm_matrix_index_counter.sv
hw/ntm_scalar_sinh_series.sv
hw/ntm_matrix_sinh_function.sv
bench/ntm_sinh_clock_gen.sv
bench/ntm_matrix_sinh_tb.sv

//--- Bender.yml
package:
  name: ntm_matrix_sinh_function

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ntm_sinh_pkg.sv
      - hw/ntm_sinh_elem_if.sv
      - hw/ntm_matrix_sinh_fsm.sv
      - hw/ntm_matrix_index_counter.sv
      - hw/ntm_scalar_sinh_series.sv
      - hw/ntm_matrix_sinh_function.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/ntm_sinh_clock_gen.sv
      - bench/ntm_matrix_sinh_tb.sv
